// File: mmioPkg.sv
// shared bus request/response types and the peripheral address map
// imported by the decoder, every peripheral and the top level
`default_nettype none

package mmioPkg;

    // ********************
    // bus widths
    // ********************
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    // one enable bit per byte lane
    localparam int BE_W   = DATA_W / 8;

    // ********************
    // address map
    // ********************
    // word addresses, low two bits ignored by the decoder
    localparam logic [ADDR_W-1:0] DISPLAY_ADDR   = 32'hFF00_0000;
    localparam logic [ADDR_W-1:0] STOPWATCH_ADDR = 32'hFF00_0010;
    localparam logic [ADDR_W-1:0] LFSR_ADDR      = 32'hFF00_0020;

    // master side of the shared data bus, 70 bits
    typedef struct packed {
        logic              readEnable;
        logic              writeEnable;
        logic [BE_W-1:0]   byteEnable;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] writeData;
    } busReq_t;

    // merged response back to the master
    typedef struct packed {
        logic [DATA_W-1:0] readData;
        // address fell inside the map
        logic              hit;
    } busRsp_t;

endpackage

`default_nettype wire

// File: displayPkg.sv
// switch codes and segment types for the seven-segment display path
// imported by the display block and the top level
`default_nettype none

package displayPkg;

    // number of hex digits on the board
    localparam int NUM_DIGITS = 6;

    // word shown on the digits, picked by the two switches
    typedef enum logic [1:0] {
        DISP_ZERO      = 2'd0,
        DISP_REG       = 2'd1,
        DISP_STOPWATCH = 2'd2,
        DISP_LFSR      = 2'd3
    } dispSel_t;

    // one nibble per digit
    typedef logic [3:0] hexDigit_t;

    // active low, bit 0 is segment a, bit 6 is segment g
    typedef logic [6:0] segments_t;

    // digit 0 shows the least significant nibble
    typedef segments_t [NUM_DIGITS-1:0] segmentBank_t;

endpackage

`default_nettype wire

// File: busDecoder.sv
// address decoder for the shared data bus
// gates the enables per peripheral and merges their read words into one response
`timescale 1ns/1ps
`default_nettype none

module busDecoder import mmioPkg::*; (
    input  busReq_t           busReq,
    input  logic [DATA_W-1:0] swData,
    input  logic [DATA_W-1:0] lfsrData,
    input  logic [DATA_W-1:0] dispData,
    output busReq_t           swReq,
    output busReq_t           lfsrReq,
    output busReq_t           dispReq,
    output busRsp_t           busRsp
);

    // one select per peripheral, mutually exclusive by the map
    logic hitDisp;
    logic hitSw;
    logic hitLfsr;

    // word compare, byte offset bits dropped
    function automatic logic wordMatch(input logic [ADDR_W-1:0] addr,
                                       input logic [ADDR_W-1:0] base);
        return addr[ADDR_W-1:2] == base[ADDR_W-1:2];
    endfunction

    // copy of the request with enables qualified by the select
    function automatic busReq_t gateReq(input busReq_t req, input logic sel);
        busReq_t gated;
        gated             = req;
        gated.readEnable  = req.readEnable & sel;
        gated.writeEnable = req.writeEnable & sel;
        return gated;
    endfunction

    // ********************
    // decode
    // ********************
    assign hitDisp = wordMatch(busReq.address, DISPLAY_ADDR);
    assign hitSw   = wordMatch(busReq.address, STOPWATCH_ADDR);
    assign hitLfsr = wordMatch(busReq.address, LFSR_ADDR);

    // payload fans out unchanged, only the strobes differ
    assign dispReq = gateReq(busReq, hitDisp);
    assign swReq   = gateReq(busReq, hitSw);
    assign lfsrReq = gateReq(busReq, hitLfsr);

    // ********************
    // read merge
    // ********************
    always_comb begin
        busRsp.hit = hitDisp | hitSw | hitLfsr;
        // unmapped address reads back as zero
        if (hitDisp) begin
            busRsp.readData = dispData;
        end else if (hitSw) begin
            busRsp.readData = swData;
        end else if (hitLfsr) begin
            busRsp.readData = lfsrData;
        end else begin
            busRsp.readData = '0;
        end
    end

endmodule

`default_nettype wire

// File: stopwatchCounter.sv
// stopwatch peripheral, a prescaled free-running tick count
// reading returns the count, any write clears count and prescaler
`timescale 1ns/1ps
`default_nettype none

module stopwatchCounter import mmioPkg::*; #(
    // clocks per tick
    parameter int TICK_DIV = 4
) (
    input  logic              iCLK,
    input  logic              arstN,
    input  busReq_t           req,
    output logic [DATA_W-1:0] readData,
    output logic [DATA_W-1:0] count
);

    // at least one bit so TICK_DIV of 1 still builds
    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICK_DIV - 1);

    logic [PRE_W-1:0]  prescaleQ;
    logic [DATA_W-1:0] countQ;

    // ********************
    // prescaler and tick count
    // ********************
    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            prescaleQ <= '0;
            countQ    <= '0;
        end else if (req.writeEnable) begin
            // clear wins over the tick in the same edge
            prescaleQ <= '0;
            countQ    <= '0;
        end else if (prescaleQ == PRE_LAST) begin
            prescaleQ <= '0;
            countQ    <= countQ + 1'b1;
        end else begin
            prescaleQ <= prescaleQ + 1'b1;
        end
    end

    // reads have no side effect here
    assign readData = countQ;
    // raw count for the display path
    assign count    = countQ;

endmodule

`default_nettype wire

// File: lfsrGenerator.sv
// pseudo-random peripheral, 32-bit right-shifting Galois LFSR
// a write seeds it, each read returns the state and steps once at that edge
`timescale 1ns/1ps
`default_nettype none

module lfsrGenerator import mmioPkg::*; #(
    // also replaces a zero seed, which would lock the register
    parameter logic [DATA_W-1:0] LFSR_RESET_SEED = 32'h0000_0001
) (
    input  logic              iCLK,
    input  logic              arstN,
    input  busReq_t           req,
    output logic [DATA_W-1:0] readData,
    output logic [DATA_W-1:0] state
);

    // feedback taps, xored in when a one drops out of bit 0
    localparam logic [DATA_W-1:0] TAP_MASK = 32'h8020_0003;

    logic [DATA_W-1:0] stateQ;

    // one Galois step
    function automatic logic [DATA_W-1:0] lfsrStep(input logic [DATA_W-1:0] cur);
        logic [DATA_W-1:0] nxt;
        nxt = cur >> 1;
        if (cur[0]) begin
            nxt = nxt ^ TAP_MASK;
        end
        return nxt;
    endfunction

    // ********************
    // seed and step
    // ********************
    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            stateQ <= LFSR_RESET_SEED;
        end else if (req.writeEnable) begin
            stateQ <= (req.writeData == '0) ? LFSR_RESET_SEED : req.writeData;
        end else if (req.readEnable) begin
            // master already sampled the old value at this edge
            stateQ <= lfsrStep(stateQ);
        end
    end

    assign readData = stateQ;
    assign state    = stateQ;

endmodule

`default_nettype wire

// File: hexDisplay.sv
// seven-segment display path with a byte-writable display register
// the switches pick the shown word, the low 24 bits drive six hex digits
`timescale 1ns/1ps
`default_nettype none

module hexDisplay import mmioPkg::*, displayPkg::*; (
    input  logic              iCLK,
    input  logic              arstN,
    input  busReq_t           req,
    input  dispSel_t          sw,
    input  logic [DATA_W-1:0] swCount,
    input  logic [DATA_W-1:0] lfsrState,
    output logic [DATA_W-1:0] readData,
    output segmentBank_t      hex
);

    logic [DATA_W-1:0] displayQ;
    logic [DATA_W-1:0] shownWord;

    // standard hex font, active low, lowercase b and d
    function automatic segments_t hexFont(input hexDigit_t digit);
        case (digit)
            4'h0:    return 7'h40;
            4'h1:    return 7'h79;
            4'h2:    return 7'h24;
            4'h3:    return 7'h30;
            4'h4:    return 7'h19;
            4'h5:    return 7'h12;
            4'h6:    return 7'h02;
            4'h7:    return 7'h78;
            4'h8:    return 7'h00;
            4'h9:    return 7'h10;
            4'hA:    return 7'h08;
            4'hB:    return 7'h03;
            4'hC:    return 7'h46;
            4'hD:    return 7'h21;
            4'hE:    return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    // ********************
    // display register
    // ********************
    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            displayQ <= '0;
        end else if (req.writeEnable) begin
            // only enabled byte lanes change
            for (int b = 0; b < BE_W; b++) begin
                if (req.byteEnable[b]) begin
                    displayQ[8*b +: 8] <= req.writeData[8*b +: 8];
                end
            end
        end
    end

    assign readData = displayQ;

    // ********************
    // word select and decode
    // ********************
    always_comb begin
        case (sw)
            DISP_LFSR:      shownWord = lfsrState;
            DISP_STOPWATCH: shownWord = swCount;
            DISP_REG:       shownWord = displayQ;
            default:        shownWord = '0;
        endcase
    end

    // one font lookup per digit, upper byte not shown
    for (genvar d = 0; d < NUM_DIGITS; d++) begin : g_digit
        assign hex[d] = hexFont(shownWord[4*d +: 4]);
    end

endmodule

`default_nettype wire

// File: mmioSubsystem.sv
// memory-mapped peripheral subsystem top, bus decoder beside its peripherals
// an outside master drives busReq; switches pick the word on the hex digits
`timescale 1ns/1ps
`default_nettype none

module mmioSubsystem import mmioPkg::*, displayPkg::*; #(
    parameter int                TICK_DIV        = 4,
    parameter logic [DATA_W-1:0] LFSR_RESET_SEED = 32'h0000_0001
) (
    input  logic         iCLK,
    input  logic         arstN,
    input  busReq_t      busReq,
    input  dispSel_t     sw,
    output busRsp_t      busRsp,
    output segmentBank_t hex
);

    // gated requests, one per peripheral
    busReq_t swReq;
    busReq_t lfsrReq;
    busReq_t dispReq;

    // read words back to the decoder
    logic [DATA_W-1:0] swData;
    logic [DATA_W-1:0] lfsrData;
    logic [DATA_W-1:0] dispData;

    // live values for the display select
    logic [DATA_W-1:0] swCount;
    logic [DATA_W-1:0] lfsrState;

    // ********************
    // bus decode
    // ********************
    busDecoder i_busDecoder (
        .busReq   (busReq),
        .swData   (swData),
        .lfsrData (lfsrData),
        .dispData (dispData),
        .swReq    (swReq),
        .lfsrReq  (lfsrReq),
        .dispReq  (dispReq),
        .busRsp   (busRsp)
    );

    // ********************
    // peripherals
    // ********************
    stopwatchCounter #(
        .TICK_DIV (TICK_DIV)
    ) i_stopwatchCounter (
        .iCLK     (iCLK),
        .arstN    (arstN),
        .req      (swReq),
        .readData (swData),
        .count    (swCount)
    );

    lfsrGenerator #(
        .LFSR_RESET_SEED (LFSR_RESET_SEED)
    ) i_lfsrGenerator (
        .iCLK     (iCLK),
        .arstN    (arstN),
        .req      (lfsrReq),
        .readData (lfsrData),
        .state    (lfsrState)
    );

    // display takes its other sources straight from the peripherals
    hexDisplay i_hexDisplay (
        .iCLK      (iCLK),
        .arstN     (arstN),
        .req       (dispReq),
        .sw        (sw),
        .swCount   (swCount),
        .lfsrState (lfsrState),
        .readData  (dispData),
        .hex       (hex)
    );

endmodule

`default_nettype wire

// File: tbMmioSubsystem.sv
// testbench for the mmio subsystem, replays bus and switch operations from a stimulus file
// run from the project root so that mmio_stimulus.txt is found
`timescale 1ns/1ps
`default_nettype none

module tbMmioSubsystem import mmioPkg::*, displayPkg::*; ();

    // ********************
    // constants
    // ********************
    localparam int CLK_HALF_NS   = 20;
    localparam int CLK_PERIOD_NS = 2 * CLK_HALF_NS;
    localparam int RESET_CYCLES  = 5;
    localparam string STIM_FILE  = "mmio_stimulus.txt";

    // operation codes of the stimulus file
    localparam int OP_WR = 0;
    localparam int OP_RD = 1;
    localparam int OP_RG = 2;
    localparam int OP_SW = 3;
    localparam int OP_ID = 4;

    // DUT ports
    logic         iCLK;
    logic         arstN;
    busReq_t      busReq;
    dispSel_t     sw;
    busRsp_t      busRsp;
    segmentBank_t hex;

    // parsed stimulus, one entry per operation line
    int          opQ[$];
    int          lineQ[$];
    logic [31:0] addrQ[$];
    logic [63:0] dataQ[$];
    logic [3:0]  beQ[$];
    logic        hitQ[$];
    logic [63:0] expQ[$];

    bit stimLoaded = 1'b0;

    mmioSubsystem i_mmioSubsystem (
        .iCLK   (iCLK),
        .arstN  (arstN),
        .busReq (busReq),
        .sw     (sw),
        .busRsp (busRsp),
        .hex    (hex)
    );

    // free-running clock
    always #(CLK_HALF_NS) iCLK = ~iCLK;

    // ********************
    // helpers
    // ********************
    task automatic failNow(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic int opCode(input string name);
        case (name)
            "wr":    return OP_WR;
            "rd":    return OP_RD;
            "rg":    return OP_RG;
            "sw":    return OP_SW;
            "id":    return OP_ID;
            default: return -1;
        endcase
    endfunction

    task automatic loadStimulus();
        int          fd;
        int          lineNo;
        int          fields;
        string       line;
        string       opName;
        logic [63:0] addrF;
        logic [63:0] dataF;
        logic [63:0] beF;
        logic [63:0] hitF;
        logic [63:0] expF;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            failNow("cannot open the stimulus file mmio_stimulus.txt");
        end
        lineNo = 0;
        while ($fgets(line, fd) != 0) begin
            lineNo++;
            // comment lines start with a hash
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h %h", opName, addrF, dataF, beF, hitF, expF);
            // blank line
            if (fields <= 0) begin
                continue;
            end
            if (fields != 6 || opCode(opName) < 0) begin
                failNow($sformatf("stimulus line %0d is malformed", lineNo));
            end
            opQ.push_back(opCode(opName));
            lineQ.push_back(lineNo);
            addrQ.push_back(addrF[31:0]);
            dataQ.push_back(dataF);
            beQ.push_back(beF[3:0]);
            hitQ.push_back(hitF[0]);
            expQ.push_back(expF);
        end
        $fclose(fd);
    endtask

    // one bus cycle, inputs change on the falling edge
    task automatic driveCycle(input busReq_t req, input dispSel_t sel,
                              output busRsp_t rsp, output segmentBank_t seg);
        @(negedge iCLK);
        busReq = req;
        sw     = sel;
        // sample in the middle of the low phase
        #(CLK_HALF_NS / 2);
        rsp = busRsp;
        seg = hex;
        @(posedge iCLK);
    endtask

    // ********************
    // compare tasks
    // ********************
    // exact when both bounds match, else an inclusive range
    task automatic checkRsp(input int lineNo, input busRsp_t got,
                            input busRsp_t expLo, input busRsp_t expHi);
        if (got.hit !== expLo.hit) begin
            failNow($sformatf("ERR busRsp.hit got %h expected %h (stimulus line %0d)",
                              got.hit, expLo.hit, lineNo));
        end
        if ($isunknown(got.readData) || got.readData < expLo.readData
                || got.readData > expHi.readData) begin
            if (expLo.readData == expHi.readData) begin
                failNow($sformatf("ERR busRsp.readData got %h expected %h (stimulus line %0d)",
                                  got.readData, expLo.readData, lineNo));
            end else begin
                failNow($sformatf("ERR busRsp.readData got %h expected %h..%h (stimulus line %0d)",
                                  got.readData, expLo.readData, expHi.readData, lineNo));
            end
        end
    endtask

    task automatic checkHex(input int lineNo, input segmentBank_t got, input segmentBank_t exp);
        if (got !== exp) begin
            failNow($sformatf("ERR hex got %h expected %h (stimulus line %0d)", got, exp, lineNo));
        end
    endtask

    // ********************
    // main sequence
    // ********************
    initial begin : mainSeq
        busReq_t           idleReq;
        busReq_t           req;
        busRsp_t           rsp;
        busRsp_t           expLo;
        busRsp_t           expHi;
        segmentBank_t      seg;
        dispSel_t          curSel;
        int                i;
        iCLK     = 1'b0;
        arstN    = 1'b0;
        busReq   = '0;
        sw       = DISP_ZERO;
        idleReq  = '0;
        curSel   = DISP_ZERO;
        loadStimulus();
        stimLoaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge iCLK);
        @(negedge iCLK);
        arstN = 1'b1;
        for (i = 0; i < opQ.size(); i++) begin
            req            = idleReq;
            req.address    = addrQ[i];
            req.writeData  = dataQ[i][31:0];
            req.byteEnable = beQ[i];
            expLo.hit      = hitQ[i];
            expLo.readData = expQ[i][31:0];
            expHi          = expLo;
            case (opQ[i])
                OP_WR: begin
                    req.writeEnable = 1'b1;
                    driveCycle(req, curSel, rsp, seg);
                end
                OP_RD: begin
                    req.readEnable = 1'b1;
                    driveCycle(req, curSel, rsp, seg);
                    checkRsp(lineQ[i], rsp, expLo, expHi);
                end
                OP_RG: begin
                    // data column is the lower bound
                    req.readEnable = 1'b1;
                    expLo.readData = dataQ[i][31:0];
                    driveCycle(req, curSel, rsp, seg);
                    checkRsp(lineQ[i], rsp, expLo, expHi);
                end
                OP_SW: begin
                    curSel = dispSel_t'(dataQ[i][1:0]);
                    driveCycle(idleReq, curSel, rsp, seg);
                    checkHex(lineQ[i], seg, segmentBank_t'(expQ[i][41:0]));
                end
                default: begin
                    repeat (int'(dataQ[i])) driveCycle(idleReq, curSel, rsp, seg);
                end
            endcase
        end
        // release the bus
        driveCycle(idleReq, curSel, rsp, seg);
        $display("TEST OK");
        $finish;
    end

    // ********************
    // watchdog
    // ********************
    // budget grows with the number of stimulus lines
    initial begin : watchdog
        longint limitNs;
        wait (stimLoaded);
        limitNs = longint'(CLK_PERIOD_NS) * (opQ.size() * 4 + 200);
        #(limitNs);
        failNow($sformatf("watchdog timeout, run still busy after %0d ns", limitNs));
    end

endmodule

`default_nettype wire

// File: mmio_stimulus.txt
# columns: op addr data be hit expected, all hex except op
# wr write, rd exact read, rg read in data..expected, sw set switches to data, id idle data cycles
# after reset
rd FF000000 00000000 0 1 00000000
rd FF000040 00000000 0 0 00000000
# byte lane writes to the display register
wr FF000000 12345678 F 0 00000000
wr FF000000 000000AB 1 0 00000000
rd FF000000 00000000 0 1 123456AB
# display path, hex value is digit 5 down to digit 0
wr FF000000 00123456 F 0 00000000
rd FF000000 00000000 0 1 00123456
sw 00000000 00000001 0 0 3CA46064902
sw 00000000 00000000 0 0 20408102040
# LFSR seed then four reads
wr FF000020 ACE10001 F 0 00000000
rd FF000020 00000000 0 1 ACE10001
rd FF000020 00000000 0 1 D6508003
rd FF000020 00000000 0 1 EB084002
rd FF000020 00000000 0 1 75842001
# zero seed falls back to the reset seed
wr FF000020 00000000 F 0 00000000
rd FF000020 00000000 0 1 00000001
# stopwatch clear, 40 idle cycles, then two reads
wr FF000010 00000000 F 0 00000000
id 00000000 00000028 0 0 00000000
rd FF000010 00000000 0 1 0000000A
rg FF000010 0000000A 0 1 0000000B

// File: flist.f
mmioPkg.sv
displayPkg.sv
busDecoder.sv
stopwatchCounter.sv
lfsrGenerator.sv
hexDisplay.sv
mmioSubsystem.sv
tbMmioSubsystem.sv

// File: Bender.yml
package:
  name: mmio_subsystem

sources:
  # packages first
  - mmioPkg.sv
  - displayPkg.sv
  # RTL
  - busDecoder.sv
  - stopwatchCounter.sv
  - lfsrGenerator.sv
  - hexDisplay.sv
  - mmioSubsystem.sv
  # testbench
  - target: test
    files:
      - tbMmioSubsystem.sv
